// ==== Bender.yml ====
package:
  name: fetch_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_trans_if.sv
      - verilog/prefetch_unit.sv
      - verilog/pma_checker.sv
      - verilog/wb_instr_master.sv
      - verilog/if_stage.sv
  - target: simulation
    files:
      - sim/fetch_assertions.sv
      - sim/fetch_tb.sv

// ==== include/fetch_config.svh ====
// Fetch buffer depth and executable region macros
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

//////////////////////////////
// Prefetch buffer
//////////////////////////////

// Words held by the prefetch ring buffer
// In-flight word counts against this too
`define FETCH_BUF_DEPTH 2

//////////////////////////////
// Executable region
//////////////////////////////

// Single PMA region, base and size in bytes
// Fetches outside return a fault word
`define FETCH_EXEC_BASE 32'h0000_0000
`define FETCH_EXEC_SIZE 32'h0001_0000

`endif

// ==== project.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_trans_if.sv
verilog/prefetch_unit.sv
verilog/pma_checker.sv
verilog/wb_instr_master.sv
verilog/if_stage.sv
sim/fetch_assertions.sv
sim/fetch_tb.sv

// ==== sim/fetch_assertions.sv ====
// Bound assertions: Wishbone strobe and address hold, IF/ID output hold under stall
`timescale 1ns/1ps

module fetch_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        wb_cyc_i,
  input logic        wb_stb_i,
  input logic [31:0] wb_adr_i,
  input logic        wb_ack_i,
  input logic        id_ready_i,
  input logic        id_valid_i,
  input logic [31:0] id_instr_i,
  input logic [31:0] id_pc_i,
  input logic        id_fault_i
);

  // Failed property count
  int unsigned err_count = 0;

  //////////////////////////////
  // Wishbone classic
  //////////////////////////////

  // Cycle and strobe stay up with a fixed address until ack
  stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb_i && !wb_ack_i) |=> (wb_cyc_i && wb_stb_i && $stable(wb_adr_i)))
    else
    begin
      $error("Wishbone strobe dropped or address moved before ack");
      err_count++;
    end

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  // ID stalled, every output holds
  id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> ($stable(id_valid_i) && $stable(id_instr_i) &&
                     $stable(id_pc_i) && $stable(id_fault_i)))
    else
    begin
      $error("IF/ID outputs changed while ID stalled");
      err_count++;
    end

endmodule

bind if_stage fetch_assertions u_fetch_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .wb_cyc_i   (wb_cyc_o),
  .wb_stb_i   (wb_stb_o),
  .wb_adr_i   (wb_adr_o),
  .wb_ack_i   (wb_ack_i),
  .id_ready_i (id_ready_i),
  .id_valid_i (id_valid_o),
  .id_instr_i (id_instr_o),
  .id_pc_i    (id_pc_o),
  .id_fault_i (id_fault_o)
);

// ==== sim/fetch_tb.sv ====
// Fetch stage testbench: clock, reset, trace reader, Wishbone memory, checks, timeout
`timescale 1ns/1ps

module fetch_tb;

  logic clk, rst_n, pc_set_i, kill_if_i, halt_if_i, id_ready_i;
  fetch_pkg::pc_mux_e     pc_mux_i;
  fetch_pkg::exc_pc_mux_e exc_pc_mux_i;
  logic [4:0]  irq_id_i;
  logic [23:0] mtvec_addr_i;
  logic [31:0] boot_addr_i, jump_target_i, branch_target_i, mepc_i;
  logic [31:0] nmi_addr_i, dm_halt_addr_i;
  logic id_valid_o, id_fault_o, mtvec_init_o, if_busy_o;
  logic [31:0] id_instr_o, id_pc_o;
  logic wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i;
  logic [31:0] wb_adr_o, wb_dat_i;
  logic [3:0]  wb_sel_o;

  // Trace contents
  logic [31:0] m_addr [64];
  logic [31:0] m_data [64];
  byte         ev_kind [32];
  logic [31:0] ev_n [32], ev_pc [32], ev_exc [32], ev_irq [32], ev_mtvec [32], ev_tgt [32];
  logic [31:0] e_pc [64], e_instr [64], e_fault [64];
  int n_mem, n_ev, n_exp, ev_idx, exp_idx, accepted, cycles, limit, boot_pulses, ack_wait;
  integer seed = 32'h903ecfb3;
  logic force_halt, do_redirect, do_kill, in_cycle;

  if_stage uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_word(input logic [31:0] got_pc, got_instr, exp_pc, exp_instr);
    if (got_pc !== exp_pc || got_instr !== exp_instr)
      fail($sformatf("MISMATCH at %0t: word %0d pc %h instr %h, expected pc %h instr %h",
        $time, exp_idx, got_pc, got_instr, exp_pc, exp_instr));
  endtask

  task automatic check_fault(input logic got, exp);
    if (got !== exp)
      fail($sformatf("MISMATCH at %0t: word %0d fault %b, expected %b",
        $time, exp_idx, got, exp));
  endtask

  // Listed words first, otherwise an address-wide pattern
  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    logic [31:0] data;
    data = addr ^ 32'h5a5a_a5a5;
    for (int i = 0; i < n_mem; i++)
      if (m_addr[i] == addr)
        data = m_data[i];
    return data;
  endfunction

  // Selected source gets the trace target, every other source a distinct decoy
  task automatic set_targets(input fetch_pkg::pc_mux_e pc_sel,
                             input fetch_pkg::exc_pc_mux_e exc_sel,
                             input logic [31:0] tgt);
    boot_addr_i     = tgt ^ 32'h0000_0010;
    jump_target_i   = tgt ^ 32'h0000_0020;
    branch_target_i = tgt ^ 32'h0000_0040;
    mepc_i          = tgt ^ 32'h0000_0080;
    nmi_addr_i      = tgt ^ 32'h0000_0400;
    dm_halt_addr_i  = tgt ^ 32'h0000_0800;
    case (pc_sel)
      fetch_pkg::PC_BOOT:   boot_addr_i     = tgt;
      fetch_pkg::PC_JUMP:   jump_target_i   = tgt;
      fetch_pkg::PC_BRANCH: branch_target_i = tgt;
      fetch_pkg::PC_MRET:   mepc_i          = tgt;
      default:
      begin
        // Trap and interrupt handlers come from mtvec alone
        if (exc_sel == fetch_pkg::EXC_PC_NMI)
          nmi_addr_i = tgt;
        else if (exc_sel == fetch_pkg::EXC_PC_DBD)
          dm_halt_addr_i = tgt;
      end
    endcase
  endtask

  task automatic load_trace();
    int fd, r;
    string line;
    byte c;
    fd = $fopen("sim/fetch_trace.txt", "r");
    if (fd == 0)
      fail("Cannot open sim/fetch_trace.txt");
    while (!$feof(fd))
    begin
      line = "";
      r = $fgets(line, fd);
      c = (line.len() > 0) ? line.getc(0) : "#";
      if (c == "M")
      begin
        r = $sscanf(line, "M %h %h", m_addr[n_mem], m_data[n_mem]);
        n_mem++;
      end
      else if (c == "R" || c == "K")
      begin
        ev_kind[n_ev] = c;
        if (c == "R")
          r = $sscanf(line, "R %h %h %h %h %h %h", ev_n[n_ev], ev_pc[n_ev], ev_exc[n_ev],
            ev_irq[n_ev], ev_mtvec[n_ev], ev_tgt[n_ev]);
        else
          r = $sscanf(line, "K %h", ev_n[n_ev]);
        n_ev++;
      end
      else if (c == "E")
      begin
        r = $sscanf(line, "E %h %h %h", e_pc[n_exp], e_instr[n_exp], e_fault[n_exp]);
        n_exp++;
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // One clock: bus, ID, checks
  //////////////////////////////

  task automatic tick();
    @(posedge clk);
    #1;
    cycles++;
    if (cycles > limit)
      fail($sformatf("Timeout after %0d cycles with %0d of %0d words seen",
        cycles, exp_idx, n_exp));
    // Wishbone slave with 0 to 3 wait cycles
    wb_ack_i = 1'b0;
    if (wb_cyc_o && wb_stb_o)
    begin
      if (!in_cycle)
      begin
        in_cycle = 1'b1;
        ack_wait = $random(seed) & 3;
      end
      if (ack_wait == 0)
      begin
        wb_ack_i  = 1'b1;
        wb_dat_i  = mem_read(wb_adr_o);
        in_cycle  = 1'b0;
      end
      else
        ack_wait--;
    end
    if (force_halt && id_valid_o)
      fail("IF/ID produced a word while fetch was halted");
    pc_set_i  = do_redirect;
    kill_if_i = do_kill;
    // Empty IF/ID at the handshake just before a trace event
    halt_if_i = force_halt ||
                (ev_idx < n_ev && accepted + 1 == ev_n[ev_idx] && id_valid_o);
    id_ready_i = ($random(seed) & 3) != 0;
    if (id_valid_o && id_ready_i)
    begin
      check_word(id_pc_o, id_instr_o, e_pc[exp_idx], e_instr[exp_idx]);
      check_fault(id_fault_o, e_fault[exp_idx][0]);
      exp_idx++;
      accepted++;
    end
  endtask

  // Combinational strobe, bus outputs and bound checker state seen mid-cycle
  always @(negedge clk)
  begin
    if (rst_n && mtvec_init_o)
      boot_pulses++;
    if (rst_n && wb_cyc_o && wb_adr_o >= 32'h0001_0000)
      fail($sformatf("Wishbone cycle at %0t outside executable region, adr %h",
        $time, wb_adr_o));
    if (rst_n && wb_cyc_o && (wb_sel_o !== 4'hF || wb_we_o !== 1'b0))
      fail($sformatf("MISMATCH at %0t: Wishbone sel %h we %b, expected sel f we 0",
        $time, wb_sel_o, wb_we_o));
    if (rst_n && wb_cyc_o && if_busy_o !== 1'b1)
      fail($sformatf("MISMATCH at %0t: if_busy_o %b in a Wishbone cycle, expected 1",
        $time, if_busy_o));
    if (uut.u_fetch_assertions.err_count != 0)
      fail("A bound assertion on the Wishbone bus or the IF/ID register failed");
  end

  initial
  begin
    {rst_n, pc_set_i, kill_if_i, halt_if_i, id_ready_i, wb_ack_i} = '0;
    pc_mux_i = fetch_pkg::PC_BOOT;
    exc_pc_mux_i = fetch_pkg::EXC_PC_EXCEPTION;
    {irq_id_i, mtvec_addr_i, wb_dat_i} = '0;
    {boot_addr_i, jump_target_i, branch_target_i, mepc_i} = '0;
    {nmi_addr_i, dm_halt_addr_i} = '0;
    {force_halt, do_redirect, do_kill, in_cycle} = '0;
    {n_mem, n_ev, n_exp, ev_idx, exp_idx, accepted, cycles, boot_pulses, ack_wait} = '0;
    load_trace();
    limit = n_exp * 40 + 200;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    while (exp_idx < n_exp)
    begin
      if (ev_idx < n_ev && accepted == ev_n[ev_idx])
      begin
        force_halt = 1'b1;
        if (ev_kind[ev_idx] == "R")
        begin
          pc_mux_i     = fetch_pkg::pc_mux_e'(ev_pc[ev_idx][2:0]);
          exc_pc_mux_i = fetch_pkg::exc_pc_mux_e'(ev_exc[ev_idx][1:0]);
          irq_id_i     = ev_irq[ev_idx][4:0];
          mtvec_addr_i = ev_mtvec[ev_idx][23:0];
          set_targets(pc_mux_i, exc_pc_mux_i, ev_tgt[ev_idx]);
          do_redirect  = 1'b1;
          tick();
        end
        else
        begin
          // Let the buffer fill, then kill its head
          repeat (10) tick();
          do_kill = 1'b1;
          tick();
        end
        {force_halt, do_redirect, do_kill} = '0;
        ev_idx++;
      end
      else
        tick();
    end
    @(negedge clk);
    #1;
    if (boot_pulses != 1)
      fail($sformatf("MISMATCH at %0t: %0d mtvec init pulses, expected 1", $time, boot_pulses));
    else if (uut.u_fetch_assertions.err_count != 0)
      fail("A bound assertion on the Wishbone bus or the IF/ID register failed");
    else
    begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== sim/fetch_trace.txt ====
# Kinds: M addr data | R after_n pc_mux exc_mux irq_id mtvec target | K after_n | E pc instr fault
# All fields hex; memory not listed reads addr ^ 5a5aa5a5
M 00000100 00000013
M 00001000 30200073
R 0 0 0 0 000010 00000101
E 00000100 00000013 0
E 00000104 5a5aa4a1 0
E 00000108 5a5aa4ad 0
R 3 1 0 0 000010 00000200
E 00000200 5a5aa7a5 0
E 00000204 5a5aa7a1 0
K 5
E 0000020c 5a5aa7a9 0
R 6 3 0 0 000010 00000000
E 00001000 30200073 0
R 7 3 1 3 000010 00000000
E 0000100c 5a5ab5a9 0
R 8 3 2 0 000010 00002002
E 00002000 5a5a85a5 0
R 9 3 3 0 000010 00003003
E 00003000 5a5a95a5 0
R a 1 0 0 000010 00020000
E 00020000 00000000 1
E 00020004 00000000 1
R c 4 0 0 000010 00000300
E 00000300 5a5aa6a5 0
R d 2 0 0 000010 00000400
E 00000400 5a5aa1a5 0
E 00000404 5a5aa1a1 0

// ==== verilog/fetch_pkg.sv ====
// Fetch stage types: PC mux selects, handler kind selects, fetch response word
package fetch_pkg;

  //////////////////////////////
  // Redirect source select
  //////////////////////////////

  typedef enum logic [2:0] {
    // Boot address, low bits cleared
    PC_BOOT      = 3'd0,
    // Jump target from ID
    PC_JUMP      = 3'd1,
    // Branch target from EX
    PC_BRANCH    = 3'd2,
    // Handler address from the exception mux
    PC_EXCEPTION = 3'd3,
    // Return from trap
    PC_MRET      = 3'd4
  } pc_mux_e;

  //////////////////////////////
  // Handler kind select
  //////////////////////////////

  typedef enum logic [1:0] {
    // Synchronous trap, mtvec base
    EXC_PC_EXCEPTION = 2'd0,
    // Vectored interrupt
    EXC_PC_IRQ       = 2'd1,
    // Non-maskable interrupt
    EXC_PC_NMI       = 2'd2,
    // Debug halt entry
    EXC_PC_DBD       = 2'd3
  } exc_pc_mux_e;

  //////////////////////////////
  // Fetch response
  //////////////////////////////

  // One instruction word plus access fault flag
  typedef struct packed {
    logic [31:0] rdata;
    logic        fault;
  } fetch_resp_t;

  // Empty word, no fault
  localparam fetch_resp_t FETCH_RESP_RESET = '{rdata: 32'h0000_0000, fault: 1'b0};

endpackage

// ==== verilog/fetch_trans_if.sv ====
// Fetch transaction interface with requester and responder modports
`timescale 1ns/1ps

interface fetch_trans_if;

  // Request channel, address held while valid is high
  logic                   trans_valid;
  logic [31:0]            trans_addr;
  logic                   trans_ready;

  // Response channel, no back-pressure
  logic                   resp_valid;
  fetch_pkg::fetch_resp_t resp;

  // Side that issues fetch addresses
  modport requester (
    output trans_valid, trans_addr,
    input  trans_ready, resp_valid, resp
  );

  // Side that answers with one response per accepted request
  modport responder (
    input  trans_valid, trans_addr,
    output trans_ready, resp_valid, resp
  );

endinterface

// ==== verilog/if_stage.sv ====
// Instruction fetch stage top: PC and handler muxes, fetch path, IF/ID register
`timescale 1ns/1ps

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [4:0]             irq_id_i,
  input  logic [23:0]            mtvec_addr_i,
  input  logic [31:0]            boot_addr_i,
  input  logic [31:0]            jump_target_i,
  input  logic [31:0]            branch_target_i,
  input  logic [31:0]            mepc_i,
  input  logic [31:0]            nmi_addr_i,
  input  logic [31:0]            dm_halt_addr_i,
  input  logic                   kill_if_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  output logic                   id_valid_o,
  output logic [31:0]            id_instr_o,
  output logic [31:0]            id_pc_o,
  output logic                   id_fault_o,
  output logic                   mtvec_init_o,
  output logic                   if_busy_o,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic [31:0]            wb_adr_o,
  output logic [3:0]             wb_sel_o,
  output logic                   wb_we_o,
  input  logic [31:0]            wb_dat_i,
  input  logic                   wb_ack_i
);

  logic [31:0]            exc_pc;
  logic [31:0]            branch_addr_n;
  logic                   prefetch_valid;
  fetch_pkg::fetch_resp_t prefetch_instr;
  logic [31:0]            pc_if;
  logic                   if_valid;
  logic                   if_ready;
  logic                   id_valid_q;
  fetch_pkg::fetch_resp_t id_resp_q;
  logic [31:0]            id_pc_q;

  fetch_trans_if core_tr ();
  fetch_trans_if bus_tr ();

  //////////////////////////////
  // Redirect address
  //////////////////////////////

  always_comb
  begin : exc_pc_mux
    unique case (exc_pc_mux_i)
      // Traps share the base
      fetch_pkg::EXC_PC_EXCEPTION: exc_pc = {mtvec_addr_i, 8'h00};
      // One word slot per interrupt id
      fetch_pkg::EXC_PC_IRQ:       exc_pc = {mtvec_addr_i, 1'b0, irq_id_i, 2'b00};
      fetch_pkg::EXC_PC_NMI:       exc_pc = {nmi_addr_i[31:2], 2'b00};
      fetch_pkg::EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[31:2], 2'b00};
      default:                     exc_pc = {mtvec_addr_i, 8'h00};
    endcase
  end

  always_comb
  begin : pc_mux
    unique case (pc_mux_i)
      fetch_pkg::PC_BOOT:      branch_addr_n = {boot_addr_i[31:2], 2'b00};
      fetch_pkg::PC_JUMP:      branch_addr_n = jump_target_i;
      fetch_pkg::PC_BRANCH:    branch_addr_n = branch_target_i;
      fetch_pkg::PC_EXCEPTION: branch_addr_n = exc_pc;
      fetch_pkg::PC_MRET:      branch_addr_n = mepc_i;
      default:                 branch_addr_n = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  // Boot redirect also initializes mtvec
  assign mtvec_init_o = pc_set_i && (pc_mux_i == fetch_pkg::PC_BOOT);

  //////////////////////////////
  // Fetch path
  //////////////////////////////

  prefetch_unit u_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (pc_set_i),
    .branch_addr_i (branch_addr_n),
    .ready_i       (if_ready),
    .valid_o       (prefetch_valid),
    .instr_o       (prefetch_instr),
    .addr_o        (pc_if),
    .busy_o        (if_busy_o),
    .tr            (core_tr.requester)
  );

  pma_checker u_pma (
    .clk     (clk),
    .rst_n   (rst_n),
    .core_tr (core_tr.responder),
    .bus_tr  (bus_tr.requester)
  );

  wb_instr_master u_wb (
    .clk      (clk),
    .rst_n    (rst_n),
    .tr       (bus_tr.responder),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_adr_o (wb_adr_o),
    .wb_sel_o (wb_sel_o),
    .wb_we_o  (wb_we_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i)
  );

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  // Kill drops the head, halt keeps it
  assign if_valid = prefetch_valid && !kill_if_i && !halt_if_i;
  assign if_ready = kill_if_i || (id_ready_i && !halt_if_i);

  always_ff @(posedge clk, negedge rst_n)
  begin : if_id_reg
    if (!rst_n)
    begin
      id_valid_q <= 1'b0;
      id_resp_q  <= fetch_pkg::FETCH_RESP_RESET;
      id_pc_q    <= '0;
    end
    else if (if_valid && id_ready_i)
    begin
      id_valid_q <= 1'b1;
      id_resp_q  <= prefetch_instr;
      id_pc_q    <= pc_if;
    end
    else if (id_ready_i)
    begin
      // Bubble when nothing is offered
      id_valid_q <= 1'b0;
    end
  end

  assign id_valid_o = id_valid_q;
  assign id_instr_o = id_resp_q.rdata;
  assign id_fault_o = id_resp_q.fault;
  assign id_pc_o    = id_pc_q;

endmodule

// ==== verilog/pma_checker.sv ====
// Executable-region checker that forwards allowed fetches and faults denied ones
`timescale 1ns/1ps
`include "fetch_config.svh"

module pma_checker (
  input  logic             clk,
  input  logic             rst_n,
  fetch_trans_if.responder core_tr,
  fetch_trans_if.requester bus_tr
);

  // Answer to a denied fetch, zero data with fault set
  localparam fetch_pkg::fetch_resp_t FAULT_RESP = '{rdata: 32'h0000_0000, fault: 1'b1};

  logic [31:0]            offset;
  logic                   allowed;
  logic                   fault_pend_q;

  //////////////////////////////
  // Region compare
  //////////////////////////////

  // Offset into the region, wraps below base
  assign offset  = core_tr.trans_addr - 32'(`FETCH_EXEC_BASE);
  assign allowed = (core_tr.trans_addr >= 32'(`FETCH_EXEC_BASE)) &&
                   (offset < 32'(`FETCH_EXEC_SIZE));

  // Allowed requests go straight to the bus
  assign bus_tr.trans_valid = core_tr.trans_valid && allowed;
  assign bus_tr.trans_addr  = core_tr.trans_addr;

  // Denied requests never wait
  assign core_tr.trans_ready = allowed ? bus_tr.trans_ready : 1'b1;

  //////////////////////////////
  // Fault response
  //////////////////////////////

  // One-cycle pending fault for a denied request
  always_ff @(posedge clk, negedge rst_n)
  begin : fault_pend
    if (!rst_n)
      fault_pend_q <= 1'b0;
    else
      fault_pend_q <= core_tr.trans_valid && !allowed;
  end

  // Bus is idle while a fault is pending
  assign core_tr.resp_valid = bus_tr.resp_valid || fault_pend_q;
  assign core_tr.resp       = fault_pend_q ? FAULT_RESP : bus_tr.resp;

endmodule

// ==== verilog/prefetch_unit.sv ====
// Prefetch unit: fetch address counter, instruction ring buffer, flush and stale discard
`timescale 1ns/1ps
`include "fetch_config.svh"

module prefetch_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic [31:0]            branch_addr_i,
  input  logic                   ready_i,
  output logic                   valid_o,
  output fetch_pkg::fetch_resp_t instr_o,
  output logic [31:0]            addr_o,
  output logic                   busy_o,
  fetch_trans_if.requester       tr
);

  localparam int DEPTH = `FETCH_BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [31:0]            fetch_addr_q;
  logic [31:0]            inflight_addr_q;
  logic                   fetch_en_q;
  logic                   outstanding_q;
  logic                   discard_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [CNT_W-1:0]       buf_cnt_q;
  logic [CNT_W-1:0]       occ;
  logic                   req_fire;
  logic                   push;
  logic                   pop;
  logic [31:0]            push_addr;
  fetch_pkg::fetch_resp_t buf_q [DEPTH];
  logic [31:0]            buf_pc_q [DEPTH];

  // Ring pointer advance, wraps at DEPTH
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1))
      nxt = '0;
    else
      nxt = ptr + 1'b1;
    return nxt;
  endfunction

  //////////////////////////////
  // Request side
  //////////////////////////////

  // Buffered words plus the live in-flight word
  assign occ = buf_cnt_q + CNT_W'(outstanding_q && !discard_q);

  // One outstanding at most, room needed, quiet during a redirect
  assign tr.trans_valid = fetch_en_q && !outstanding_q && (occ < CNT_W'(DEPTH)) && !flush_i;
  assign tr.trans_addr  = fetch_addr_q;
  assign req_fire       = tr.trans_valid && tr.trans_ready;

  // Address of the word that answers now
  assign push_addr = outstanding_q ? inflight_addr_q : fetch_addr_q;

  // Stale responses and responses in a flush cycle are dropped
  assign push = tr.resp_valid && !discard_q && !flush_i;
  assign pop  = valid_o && ready_i && !flush_i;

  always_ff @(posedge clk, negedge rst_n)
  begin : req_ctrl
    if (!rst_n)
    begin
      fetch_addr_q  <= '0;
      fetch_en_q    <= 1'b0;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
    end
    else
    begin
      // Fetching begins with the first redirect
      if (flush_i)
      begin
        fetch_en_q   <= 1'b1;
        fetch_addr_q <= branch_addr_i;
      end
      else if (req_fire)
      begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      // Cleared by any response, same-cycle answers included
      outstanding_q <= !tr.resp_valid && (outstanding_q || req_fire);
      // Mark the in-flight transfer as stale
      if (flush_i && outstanding_q && !tr.resp_valid)
        discard_q <= 1'b1;
      else if (tr.resp_valid)
        discard_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin : req_addr
    if (req_fire)
      inflight_addr_q <= fetch_addr_q;
  end

  //////////////////////////////
  // Instruction buffer
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin : buf_ctrl
    if (!rst_n)
    begin
      rd_ptr_q  <= '0;
      wr_ptr_q  <= '0;
      buf_cnt_q <= '0;
    end
    else if (flush_i)
    begin
      // Redirect empties the buffer at once
      rd_ptr_q  <= '0;
      wr_ptr_q  <= '0;
      buf_cnt_q <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      buf_cnt_q <= buf_cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk)
  begin : buf_data
    if (push)
    begin
      buf_q[wr_ptr_q]    <= tr.resp;
      buf_pc_q[wr_ptr_q] <= push_addr;
    end
  end

  // Head of buffer toward IF
  assign valid_o = (buf_cnt_q != '0);
  assign instr_o = buf_q[rd_ptr_q];
  assign addr_o  = buf_pc_q[rd_ptr_q];
  assign busy_o  = outstanding_q || tr.trans_valid;

endmodule

// ==== verilog/wb_instr_master.sv ====
// Wishbone classic read master for instruction words
`timescale 1ns/1ps

module wb_instr_master (
  input  logic             clk,
  input  logic             rst_n,
  fetch_trans_if.responder tr,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output logic [31:0]      wb_adr_o,
  output logic [3:0]       wb_sel_o,
  output logic             wb_we_o,
  input  logic [31:0]      wb_dat_i,
  input  logic             wb_ack_i
);

  logic        cyc_q;
  logic [31:0] adr_q;
  logic        ack;

  // Ack only counts inside an open cycle
  assign ack = cyc_q && wb_ack_i;

  // New request only when the bus is free
  assign tr.trans_ready = !cyc_q;

  always_ff @(posedge clk, negedge rst_n)
  begin : cyc_reg
    if (!rst_n)
      cyc_q <= 1'b0;
    else if (ack)
      cyc_q <= 1'b0;
    else if (tr.trans_valid && !cyc_q)
      cyc_q <= 1'b1;
  end

  // Address held for the whole cycle
  always_ff @(posedge clk)
  begin : adr_reg
    if (tr.trans_valid && !cyc_q)
      adr_q <= tr.trans_addr;
  end

  // Read-only, full word
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = adr_q;
  assign wb_sel_o = 4'hF;
  assign wb_we_o  = 1'b0;

  // Response in the ack cycle
  assign tr.resp_valid = ack;
  assign tr.resp       = '{rdata: wb_dat_i, fault: 1'b0};

endmodule
